/* sprite_pkg.sv */
package sprite_pkg;

    // ----------------------------------------
    // Screen and sprite geometry
    // ----------------------------------------
    localparam int H_RES = 16;
    localparam int V_RES = 8;
    localparam int X_W   = 10;
    localparam int Y_W   = 9;

    localparam int NUM_SPRITES  = 4;
    localparam int SPRITE_SIZE  = 4;
    localparam int NUM_PATTERNS = 4;

    // Derived widths
    localparam int SEL_W     = $clog2(NUM_SPRITES);
    localparam int SPR_W     = $clog2(SPRITE_SIZE);
    localparam int PAT_W     = $clog2(NUM_PATTERNS);
    localparam int ROM_DEPTH = NUM_PATTERNS * SPRITE_SIZE * SPRITE_SIZE;
    localparam int ROM_AW    = $clog2(ROM_DEPTH);

    // Colour key, texels of this value show the background
    localparam logic [23:0] TRANSPARENT = 24'h000000;

    // ----------------------------------------
    // Shared types
    // ----------------------------------------
    typedef struct packed {
        logic             enable;
        logic [PAT_W-1:0] pattern;
        logic [X_W-1:0]   x;
        logic [Y_W-1:0]   y;
    } sprite_attr_t;

    // Selector result handed to the fetcher
    typedef struct packed {
        logic             hit;
        logic [PAT_W-1:0] pattern;
        logic [SPR_W-1:0] row;
        logic [SPR_W-1:0] col;
    } texel_req_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LATCH,
        ST_READ,
        ST_FETCH,
        ST_WRITE
    } ctrl_state_e;

endpackage

/* sprite_regs.sv */
`timescale 1ns/1ps

module sprite_regs (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     avalon_write,
    input  logic [7:0]               avalon_address,
    input  logic [31:0]              avalon_writedata,
    input  logic                     latch,
    output sprite_pkg::sprite_attr_t active_sprites [sprite_pkg::NUM_SPRITES]
);

    import sprite_pkg::*;

    sprite_attr_t shadow [NUM_SPRITES];
    sprite_attr_t wr_attr;
    logic         wr_hit;

    // Unpack bus word into attribute fields
    always_comb begin
        wr_attr.enable  = avalon_writedata[28];
        wr_attr.pattern = avalon_writedata[27:26];
        wr_attr.x       = avalon_writedata[18:9];
        wr_attr.y       = avalon_writedata[8:0];
    end

    // Addresses past the last sprite are dropped
    assign wr_hit = avalon_write && (avalon_address < 8'(NUM_SPRITES));

    // ----------------------------------------
    // Shadow table, written at any time
    // ----------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            shadow <= '{default: '0};
        end else if (wr_hit) begin
            shadow[avalon_address[SEL_W-1:0]] <= wr_attr;
        end
    end

    // ----------------------------------------
    // Active table, copied once per frame
    // ----------------------------------------
    // Old shadow contents are taken, so a write in the latch cycle
    // only shows up on the next frame
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            active_sprites <= '{default: '0};
        end else if (latch) begin
            active_sprites <= shadow;
        end
    end

endmodule

/* pixel_counter.sv */
`timescale 1ns/1ps

module pixel_counter (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       pc_enable,
    output logic [sprite_pkg::X_W-1:0] pixel_x,
    output logic [sprite_pkg::Y_W-1:0] pixel_y,
    output logic                       frame_start
);

    import sprite_pkg::*;

    logic x_last;
    logic y_last;

    assign x_last = (pixel_x == X_W'(H_RES - 1));
    assign y_last = (pixel_y == Y_W'(V_RES - 1));

    // Raster scan, one step per written pixel
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pixel_x <= '0;
            pixel_y <= '0;
        end else if (pc_enable) begin
            if (x_last) begin
                pixel_x <= '0;
                // Wrap to the top at frame end
                pixel_y <= y_last ? '0 : pixel_y + 1'b1;
            end else begin
                pixel_x <= pixel_x + 1'b1;
            end
        end
    end

    assign frame_start = (pixel_x == '0) && (pixel_y == '0);

endmodule

/* sprite_selector.sv */
`timescale 1ns/1ps

module sprite_selector (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       start_fetch,
    input  sprite_pkg::sprite_attr_t   active_sprites [sprite_pkg::NUM_SPRITES],
    input  logic [sprite_pkg::X_W-1:0] pixel_x,
    input  logic [sprite_pkg::Y_W-1:0] pixel_y,
    output sprite_pkg::texel_req_t     texel_req
);

    import sprite_pkg::*;

    logic [X_W-1:0]         dx [NUM_SPRITES];
    logic [Y_W-1:0]         dy [NUM_SPRITES];
    logic [NUM_SPRITES-1:0] visible;
    texel_req_t             pick;

    // ----------------------------------------
    // Visibility per sprite
    // ----------------------------------------
    // Offset is only meaningful when the pixel is right of / below
    // the origin, hence the explicit >= tests
    always_comb begin
        for (int i = 0; i < NUM_SPRITES; i++) begin
            dx[i] = pixel_x - active_sprites[i].x;
            dy[i] = pixel_y - active_sprites[i].y;
            visible[i] = active_sprites[i].enable
                         && (pixel_x >= active_sprites[i].x)
                         && (pixel_y >= active_sprites[i].y)
                         && (dx[i] < X_W'(SPRITE_SIZE))
                         && (dy[i] < Y_W'(SPRITE_SIZE));
        end
    end

    // ----------------------------------------
    // Priority pick
    // ----------------------------------------
    // Scan downwards so the lowest index overwrites the rest
    always_comb begin
        pick = '0;
        for (int i = NUM_SPRITES - 1; i >= 0; i--) begin
            if (visible[i]) begin
                pick.hit     = 1'b1;
                pick.pattern = active_sprites[i].pattern;
                pick.row     = dy[i][SPR_W-1:0];
                pick.col     = dx[i][SPR_W-1:0];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            texel_req <= '0;
        end else if (start_fetch) begin
            texel_req <= pick;
        end
    end

endmodule

/* sprite_fetcher.sv */
`timescale 1ns/1ps

module sprite_fetcher (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   bg_capture,
    input  logic [23:0]            bg_pixel,
    input  sprite_pkg::texel_req_t texel_req,
    output logic                   fetch_done,
    output logic [23:0]            pixel_out
);

    import sprite_pkg::*;

    logic [23:0]       rom [ROM_DEPTH];
    logic [ROM_AW-1:0] rom_addr;
    logic [23:0]       rom_q;
    logic              hit_q;
    logic [23:0]       bg_q;
    logic              cap_d;

    // ----------------------------------------
    // Pattern ROM contents
    // ----------------------------------------
    // Texel colour is {red, ~red, pattern}; odd patterns get a
    // transparent main diagonal
    initial begin
        logic [7:0] red;
        int         idx;
        for (int p = 0; p < NUM_PATTERNS; p++) begin
            for (int r = 0; r < SPRITE_SIZE; r++) begin
                for (int c = 0; c < SPRITE_SIZE; c++) begin
                    idx = (p * SPRITE_SIZE + r) * SPRITE_SIZE + c;
                    red = 8'(p * 64 + r * 4 + c + 1);
                    if ((p % 2 == 1) && (r == c)) begin
                        rom[idx] = TRANSPARENT;
                    end else begin
                        rom[idx] = {red, ~red, 8'(p)};
                    end
                end
            end
        end
    end

    assign rom_addr = {texel_req.pattern, texel_req.row, texel_req.col};

    // Synchronous read, hit flag kept in step with the data
    always_ff @(posedge clk) begin
        rom_q <= rom[rom_addr];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hit_q <= 1'b0;
        end else begin
            hit_q <= texel_req.hit;
        end
    end

    // Background pixel held until the next pop
    always_ff @(posedge clk) begin
        if (bg_capture) begin
            bg_q <= bg_pixel;
        end
    end

    // Two-stage delay: selector register, then ROM register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cap_d      <= 1'b0;
            fetch_done <= 1'b0;
        end else begin
            cap_d      <= bg_capture;
            fetch_done <= cap_d;
        end
    end

    // ----------------------------------------
    // Result merge
    // ----------------------------------------
    assign pixel_out = (hit_q && (rom_q != TRANSPARENT)) ? rom_q : bg_q;

endmodule

/* composer_ctrl.sv */
`timescale 1ns/1ps

module composer_ctrl (
    input  logic clk,
    input  logic arst_n,
    input  logic bg_fifo_empty,
    input  logic wrfull,
    input  logic fetch_done,
    input  logic frame_start,
    output logic latch,
    output logic new_frame,
    output logic bg_rdreq,
    output logic start_fetch,
    output logic pc_enable,
    output logic wrreq
);

    import sprite_pkg::*;

    ctrl_state_e state;
    ctrl_state_e next_state;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // ----------------------------------------
    // Next state
    // ----------------------------------------
    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE:  next_state = frame_start ? ST_LATCH : ST_READ;
            ST_LATCH: next_state = ST_READ;
            ST_READ:  if (!bg_fifo_empty) next_state = ST_FETCH;
            ST_FETCH: if (fetch_done) next_state = ST_WRITE;
            ST_WRITE: if (!wrfull) next_state = ST_IDLE;
            default:  next_state = ST_IDLE;
        endcase
    end

    // Strobes, one cycle each
    assign latch     = (state == ST_LATCH);
    assign new_frame = (state == ST_LATCH);

    // Pop and fetch launch together
    assign bg_rdreq    = (state == ST_READ) && !bg_fifo_empty;
    assign start_fetch = bg_rdreq;

    // Counter moves only when the pixel is actually accepted
    assign wrreq     = (state == ST_WRITE) && !wrfull;
    assign pc_enable = wrreq;

endmodule

/* composer.sv */
`timescale 1ns/1ps

module composer (
    input  logic        clk,
    input  logic        arst_n,

    // Register port
    input  logic        avalon_write,
    input  logic [7:0]  avalon_address,
    input  logic [31:0] avalon_writedata,

    // Background FIFO, show-ahead
    input  logic [23:0] bg_fifo_q,
    input  logic        bg_fifo_empty,
    output logic        bg_fifo_rdreq,

    // Output video FIFO
    input  logic        wrfull,
    output logic        wrreq,
    output logic [23:0] pixel_out,

    output logic        new_frame
);

    import sprite_pkg::*;

    sprite_attr_t   active_sprites [NUM_SPRITES];
    texel_req_t     texel_req;
    logic [X_W-1:0] pixel_x;
    logic [Y_W-1:0] pixel_y;
    logic           frame_start;
    logic           latch;
    logic           start_fetch;
    logic           pc_enable;
    logic           fetch_done;

    // ----------------------------------------
    // Decode
    // ----------------------------------------
    sprite_regs regs_inst (
        .clk              (clk),
        .arst_n           (arst_n),
        .avalon_write     (avalon_write),
        .avalon_address   (avalon_address),
        .avalon_writedata (avalon_writedata),
        .latch            (latch),
        .active_sprites   (active_sprites)
    );

    pixel_counter pc_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .pc_enable   (pc_enable),
        .pixel_x     (pixel_x),
        .pixel_y     (pixel_y),
        .frame_start (frame_start)
    );

    // ----------------------------------------
    // Execute and result
    // ----------------------------------------
    sprite_selector selector_inst (
        .clk            (clk),
        .arst_n         (arst_n),
        .start_fetch    (start_fetch),
        .active_sprites (active_sprites),
        .pixel_x        (pixel_x),
        .pixel_y        (pixel_y),
        .texel_req      (texel_req)
    );

    sprite_fetcher fetcher_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .bg_capture (bg_fifo_rdreq),
        .bg_pixel   (bg_fifo_q),
        .texel_req  (texel_req),
        .fetch_done (fetch_done),
        .pixel_out  (pixel_out)
    );

    // ----------------------------------------
    // Sequencing
    // ----------------------------------------
    composer_ctrl ctrl_inst (
        .clk           (clk),
        .arst_n        (arst_n),
        .bg_fifo_empty (bg_fifo_empty),
        .wrfull        (wrfull),
        .fetch_done    (fetch_done),
        .frame_start   (frame_start),
        .latch         (latch),
        .new_frame     (new_frame),
        .bg_rdreq      (bg_fifo_rdreq),
        .start_fetch   (start_fetch),
        .pc_enable     (pc_enable),
        .wrreq         (wrreq)
    );

endmodule

/* tb_composer.sv */
`timescale 1ns/1ps

module tb_composer;

    import sprite_pkg::*;

    localparam int PIXELS      = H_RES * V_RES;
    localparam int TEST_FRAMES = 10;
    // Worst case of 12 cycles per pixel at 10 ns, plus reset and margin
    localparam int WATCHDOG_NS = TEST_FRAMES * PIXELS * 12 * 10 + 20000;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        avalon_write;
    logic [7:0]  avalon_address;
    logic [31:0] avalon_writedata;
    logic [23:0] bg_fifo_q;
    logic        bg_fifo_empty;
    logic        bg_fifo_rdreq;
    logic        wrfull;
    logic        wrreq;
    logic [23:0] pixel_out;
    logic        new_frame;

    // FIFO models and reference state
    integer       seed = 87004;
    logic [23:0]  bg_queue [$];
    logic [23:0]  act_q [$];
    logic [23:0]  exp_q [$];
    logic [23:0]  last_bg;
    sprite_attr_t shd_tab [NUM_SPRITES];
    sprite_attr_t act_tab [NUM_SPRITES];
    int           pos_x = 0;
    int           pos_y = 0;
    int           wr_count = 0;
    int           rd_count = 0;
    int           nf_count = 0;
    int           sprite_px = 0;
    int           empty_gap = 0;
    int           full_gap = 0;
    bit           stall_mode = 1'b0;
    int           errors = 0;
    int           tests_passed = 0;
    int           tests_failed = 0;

    composer dut (
        .clk              (clk),
        .arst_n           (arst_n),
        .avalon_write     (avalon_write),
        .avalon_address   (avalon_address),
        .avalon_writedata (avalon_writedata),
        .bg_fifo_q        (bg_fifo_q),
        .bg_fifo_empty    (bg_fifo_empty),
        .bg_fifo_rdreq    (bg_fifo_rdreq),
        .wrfull           (wrfull),
        .wrreq            (wrreq),
        .pixel_out        (pixel_out),
        .new_frame        (new_frame)
    );

    always #5 clk = ~clk;

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic logic [23:0] rom_texel(input int p, input int r, input int c);
        logic [7:0] red;
        red = 8'(p * 64 + r * 4 + c + 1);
        if ((p % 2 == 1) && (r == c)) begin
            return TRANSPARENT;
        end
        return {red, ~red, 8'(p)};
    endfunction

    function automatic sprite_attr_t decode_word(input logic [31:0] w);
        sprite_attr_t a;
        a.enable  = w[28];
        a.pattern = w[27:26];
        a.x       = w[18:9];
        a.y       = w[8:0];
        return a;
    endfunction

    function automatic logic [31:0] attr_word(input logic en, input logic [1:0] pat,
                                              input int x, input int y);
        return {3'b000, en, pat, 7'b0, 10'(x), 9'(y)};
    endfunction

    // Lowest enabled sprite covering the pixel wins and clear texels show bg
    function automatic logic [23:0] predict(input int x, input int y, input logic [23:0] bg);
        logic [23:0] res;
        logic [23:0] tex;
        bit          found;
        int          sx;
        int          sy;
        res = bg;
        found = 1'b0;
        for (int i = 0; i < NUM_SPRITES; i++) begin
            sx = int'(act_tab[i].x);
            sy = int'(act_tab[i].y);
            if (!found && act_tab[i].enable && x >= sx && x < sx + SPRITE_SIZE
                    && y >= sy && y < sy + SPRITE_SIZE) begin
                found = 1'b1;
                tex = rom_texel(int'(act_tab[i].pattern), y - sy, x - sx);
                if (tex != TRANSPARENT) begin
                    res = tex;
                end
            end
        end
        return res;
    endfunction

    // ----------------------------------------
    // FIFO models and bus monitor
    // ----------------------------------------
    always @(posedge clk) begin
        logic        rd;
        logic        wr;
        logic        nf;
        logic        aw;
        logic [7:0]  addr;
        logic [31:0] wdata;
        logic [23:0] px;
        rd = bg_fifo_rdreq;
        wr = wrreq;
        nf = new_frame;
        aw = avalon_write;
        addr = avalon_address;
        wdata = avalon_writedata;
        px = pixel_out;
        #1;
        if (rd) begin
            if (bg_queue.size() == 0) begin
                $display("Read request at %0t while the background FIFO was empty", $time);
                errors++;
            end else begin
                last_bg = bg_queue.pop_front();
            end
            rd_count++;
        end
        if (wr) begin
            act_q.push_back(px);
            exp_q.push_back(predict(pos_x, pos_y, last_bg));
            // Output differs from its background only where a texel shows
            if (px !== last_bg) sprite_px++;
            wr_count++;
            pos_x = (pos_x + 1) % H_RES;
            if (pos_x == 0) pos_y = (pos_y + 1) % V_RES;
        end
        // Latch takes the old shadow so a write in the same cycle lands after it
        if (nf) begin
            act_tab = shd_tab;
            nf_count++;
        end
        if (aw && addr < 8'd4) shd_tab[addr[1:0]] = decode_word(wdata);
        if (!stall_mode) begin
            empty_gap = 0;
            full_gap = 0;
        end else begin
            if (empty_gap > 0) empty_gap--;
            else if (($random(seed) & 3) == 0) empty_gap = {$random(seed)} % 5;
            if (full_gap > 0) full_gap--;
            else if (($random(seed) & 3) == 0) full_gap = {$random(seed)} % 5;
        end
        bg_fifo_empty = (bg_queue.size() == 0) || (empty_gap > 0);
        bg_fifo_q = (bg_queue.size() > 0) ? bg_queue[0] : 24'h0;
        wrfull = (full_gap > 0);
    end

    // ----------------------------------------
    // Compare tasks
    // ----------------------------------------
    task automatic check_pixel(input logic [23:0] got, input logic [23:0] exp, input int idx);
        if (got !== exp) begin
            $display("FAILED %0t: pixel %0d got %06h expected %06h", $time, idx, got, exp);
            errors++;
        end
    endtask

    task automatic check_attr(input sprite_attr_t got, input sprite_attr_t exp, input int idx);
        if (got !== exp) begin
            $display("FAILED %0t: active sprite %0d got %h expected %h", $time, idx, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("FAILED %0t: %s got %b expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("FAILED %0t: %s got %0d expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------
    task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
        @(posedge clk);
        #1;
        avalon_write = 1'b1;
        avalon_address = addr;
        avalon_writedata = data;
        @(posedge clk);
        #1;
        avalon_write = 1'b0;
    endtask

    task automatic queue_background();
        for (int k = 0; k < PIXELS; k++) begin
            bg_queue.push_back(24'($random(seed)));
        end
    endtask

    // One frame of background in, then compare all 128 written pixels
    task automatic run_frame(input bit mid_write, input logic [7:0] addr,
                             input logic [31:0] data);
        int wr_start;
        int nf_start;
        int idx;
        wr_start = wr_count;
        nf_start = nf_count;
        sprite_px = 0;
        // The first frame is already queued by the reset test
        if (bg_queue.size() == 0) begin
            queue_background();
        end
        if (mid_write) begin
            wait (wr_count >= wr_start + PIXELS / 2);
            reg_write(addr, data);
        end
        wait (wr_count == wr_start + PIXELS);
        wait (nf_count > nf_start);
        // Room for a stray write or pulse to show up
        repeat (4) @(posedge clk);
        #2;
        check_count(wr_count - wr_start, PIXELS, "writes per frame");
        check_count(nf_count - nf_start, 1, "new_frame pulses per frame");
        idx = 0;
        while (act_q.size() > 0) begin
            check_pixel(act_q.pop_front(), exp_q.pop_front(), idx);
            idx++;
        end
        for (int i = 0; i < NUM_SPRITES; i++) begin
            check_attr(dut.regs_inst.active_sprites[i], act_tab[i], i);
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        if (errors == err_before) begin
            tests_passed++;
            $display("%s: done, no errors", name);
        end else begin
            tests_failed++;
            $display("%s: done, %0d errors", name, errors - err_before);
        end
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic test_reset();
        int e;
        int waited;
        e = errors;
        // Background data waits during reset so an early read would show
        queue_background();
        repeat (16) begin
            @(negedge clk);
            check_bit(wrreq, 1'b0, "wrreq in reset");
            check_bit(bg_fifo_rdreq, 1'b0, "bg_fifo_rdreq in reset");
            check_bit(new_frame, 1'b0, "new_frame in reset");
        end
        @(posedge clk);
        #1;
        arst_n = 1'b1;
        @(negedge clk);
        check_bit(wrreq, 1'b0, "wrreq after reset");
        check_bit(bg_fifo_rdreq, 1'b0, "bg_fifo_rdreq after reset");
        check_bit(new_frame, 1'b0, "new_frame after reset");
        waited = 0;
        while (nf_count == 0 && waited < 8) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (nf_count == 0) begin
            $display("No new_frame pulse within 8 cycles after reset");
            errors++;
        end
        check_count(rd_count, 0, "reads before first new_frame");
        report_test("reset state", e);
    endtask

    task automatic test_background();
        int e;
        e = errors;
        run_frame(1'b0, 8'd0, 32'd0);
        report_test("background only", e);
    endtask

    task automatic test_single_sprite();
        int e;
        e = errors;
        reg_write(8'd1, attr_word(1'b1, 2'd2, 5, 2));
        // Takes effect one frame later
        run_frame(1'b0, 8'd0, 32'd0);
        run_frame(1'b0, 8'd0, 32'd0);
        check_count(sprite_px, 16, "sprite pixels with one sprite");
        report_test("single sprite", e);
    endtask

    task automatic test_priority();
        int e;
        e = errors;
        reg_write(8'd1, 32'd0);
        reg_write(8'd0, attr_word(1'b1, 2'd1, 8, 3));
        reg_write(8'd3, attr_word(1'b1, 2'd2, 10, 4));
        run_frame(1'b0, 8'd0, 32'd0);
        run_frame(1'b0, 8'd0, 32'd0);
        // 12 opaque from sprite 0, 10 uncovered from sprite 3
        check_count(sprite_px, 22, "sprite pixels with overlap");
        report_test("priority and transparency", e);
    endtask

    task automatic test_latching();
        int e;
        e = errors;
        run_frame(1'b1, 8'd2, attr_word(1'b1, 2'd3, 0, 0));
        check_count(sprite_px, 22, "sprite pixels in frame of mid write");
        reg_write(8'd7, attr_word(1'b1, 2'd0, 12, 0));
        run_frame(1'b0, 8'd0, 32'd0);
        check_count(sprite_px, 34, "sprite pixels after latch");
        run_frame(1'b0, 8'd0, 32'd0);
        check_count(sprite_px, 34, "sprite pixels after ignored write");
        report_test("frame-boundary latching", e);
    endtask

    task automatic test_backpressure();
        int e;
        e = errors;
        stall_mode = 1'b1;
        reg_write(8'd1, attr_word(1'b1, 2'd2, 13, 6));
        run_frame(1'b0, 8'd0, 32'd0);
        run_frame(1'b0, 8'd0, 32'd0);
        stall_mode = 1'b0;
        report_test("back-pressure", e);
    endtask

    initial begin
        arst_n = 1'b0;
        avalon_write = 1'b0;
        avalon_address = 8'd0;
        avalon_writedata = 32'd0;
        bg_fifo_q = 24'd0;
        bg_fifo_empty = 1'b1;
        wrfull = 1'b0;
        shd_tab = '{default: '0};
        act_tab = '{default: '0};
        last_bg = 24'd0;
        test_reset();
        test_background();
        test_single_sprite();
        test_priority();
        test_latching();
        test_backpressure();
        $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

/* files.f */
sprite_pkg.sv
sprite_regs.sv
pixel_counter.sv
sprite_selector.sv
sprite_fetcher.sv
composer_ctrl.sv
composer.sv
tb_composer.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the composer testbench with Verilator
set -u
cd "$(dirname "$0")"

verilator --binary --timing -f files.f --top-module tb_composer -o sim_composer
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output="$(./obj_dir/sim_composer)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TESTBENCH PASSED"; then
    exit 0
fi
exit 1
